//--- alu_pipe_top.f
rtl/alu_pipe_pkg.sv
rtl/rf_ram.sv
rtl/rf_bypass.sv
rtl/pipe_ctrl.sv
rtl/alu_exec.sv
rtl/alu_pipe_top.sv
bench/alu_pipe_asserts.sv
bench/alu_pipe_tb.sv

//--- bench/alu_pipe_asserts.sv
/* Bound to alu_pipe_top; assumes op_valid_i stays low while rst is high.
   Latency check expects exactly four cycles from issue to retire. */
`timescale 1ns/1ps

module alu_pipe_asserts (
   input logic              clk,
   input logic              rst,
   input logic              op_valid_i,
   input alu_pipe_pkg::wr_t retire_i
);

   // Synchronous reset has cleared W by the following edge
   reset_clears_retire: assert property (
      @(posedge clk) rst |=> !retire_i.valid
   ) else $error("retire_o.valid high after a reset cycle");

   // Sampled at edge k, W is loaded at edge k+4 and seen valid at edge k+5
   retire_after_four: assert property (
      @(posedge clk) disable iff (rst)
      op_valid_i |-> ##5 retire_i.valid
   ) else $error("No retire four cycles after op_valid_i");

   retire_value_known: assert property (
      @(posedge clk) disable iff (rst)
      retire_i.valid |-> !$isunknown(retire_i.value)
   ) else $error("retire_o.value unknown while valid");

endmodule

//--- bench/alu_pipe_cases.txt
// opcode rd ra rb imm expected gap, all hex; opcodes 0 add 1 sub 2 and 3 or 4 xor 5 ldi
// gap is idle cycles before issue, f picks 0 to 2 at random
5 1 0 0 1234 00001234 0
5 2 0 0 00f0 000000f0 0
5 3 0 0 ffff 0000ffff 0
5 4 0 0 8001 00008001 0
0 5 1 2 0000 00001324 4
1 6 2 1 0000 ffffeebc 4
2 7 3 4 0000 00008001 4
3 8 1 2 0000 000012f4 4
4 9 1 3 0000 0000edcb 4
1 a 6 5 0000 ffffdb98 4
5 b 0 0 0005 00000005 4
0 c b 1 0000 00001239 0
1 d 2 c 0000 ffffeeb7 0
0 e d d 0000 ffffdd6e 0
3 f e b 0000 ffffdd6f 0
5 0 0 0 00aa 000000aa 4
0 1 0 2 0000 0000019a 1
2 2 3 1 0000 0000019a 1
0 3 2 2 0000 00000334 1
1 4 3 1 0000 0000019a 2
3 5 0 4 0000 000001ba 2
0 6 5 5 0000 00000374 2
5 8 0 0 0010 00000010 4
5 9 0 0 0003 00000003 0
1 a 8 9 0000 0000000d 1
0 b a 8 0000 0000001d 0
5 c 0 0 7777 00007777 4
4 d c 1 0000 000076ed 3
2 e 3 d 0000 00000224 3
0 f e e 0000 00000448 3
3 0 f c 0000 0000777f 2
0 1 0 f 0000 00007bc7 f
1 2 1 0 0000 00000448 f
4 3 2 1 0000 00007f8f f
5 4 0 0 ffff 0000ffff f
2 5 4 3 0000 00007f8f f
1 6 5 4 0000 ffff7f90 f
3 7 6 2 0000 ffff7fd8 f

//--- bench/alu_pipe_tb.sv
/* Reads bench/alu_pipe_cases.txt relative to the project root, so run from there.
   Each line is one operation, its expected result and the idle cycles before it. */
`timescale 1ns/1ps

module alu_pipe_tb;

   localparam int CLK_HALF   = 50;
   localparam int RST_CYCLES = 10;
   localparam int COLS       = 7;
   localparam int MAX_CASES  = 64;
   localparam logic [31:0] GAP_RANDOM = 32'hf;

   logic              clk;
   logic              rst;
   logic              op_valid;
   alu_pipe_pkg::op_t op;
   alu_pipe_pkg::wr_t retire;

   logic [31:0]       cases [COLS*MAX_CASES];
   alu_pipe_pkg::wr_t exp_q [$];
   int                n_cases;
   int                n_retired;
   integer            seed;

   alu_pipe_top uut (
      .clk        (clk),
      .rst        (rst),
      .op_valid_i (op_valid),
      .op_i       (op),
      .retire_o   (retire)
   );

   bind alu_pipe_top alu_pipe_asserts u_asserts (
      .clk        (clk),
      .rst        (rst),
      .op_valid_i (op_valid_i),
      .retire_i   (retire_o)
   );

   always #CLK_HALF clk = ~clk;

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "Run stopped at %0d ns", $time);
   endtask

   task automatic check_retire(input alu_pipe_pkg::wr_t got, input alu_pipe_pkg::wr_t exp);
      if (got.rd !== exp.rd) begin
         $display("[FAIL] time %0d ns: retire_o.rd got %0d expected %0d",
                  $time, got.rd, exp.rd);
         abort_run();
      end else if (got.value !== exp.value) begin
         $display("[FAIL] time %0d ns: retire_o.value got %08h expected %08h",
                  $time, got.value, exp.value);
         abort_run();
      end
   endtask

   // Table ends at the first opcode word left at all ones
   function automatic int count_cases();
      int n;
      n = 0;
      while (n < MAX_CASES && cases[n*COLS] != '1) begin
         n++;
      end
      return n;
   endfunction

   // Retire record is registered, stable at the falling edge
   always @(negedge clk) begin
      if (!rst && retire.valid) begin
         if (exp_q.size() == 0) begin
            $display("Retire of r%0d at %0d ns with no operation outstanding",
                     retire.rd, $time);
            abort_run();
         end else begin
            check_retire(retire, exp_q.pop_front());
            n_retired++;
         end
      end
   end

   initial begin : stimulus
      int                base;
      int                gap;
      alu_pipe_pkg::wr_t exp_rec;

      clk       = 1'b0;
      rst       = 1'b1;
      op_valid  = 1'b0;
      op        = '0;
      seed      = 89007;
      n_retired = 0;
      for (int i = 0; i < COLS*MAX_CASES; i++) begin
         cases[i] = '1;
      end
      $readmemh("bench/alu_pipe_cases.txt", cases);
      n_cases = count_cases();
      if (n_cases == 0) begin
         $display("No operations found in bench/alu_pipe_cases.txt");
         abort_run();
      end

      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < n_cases; i++) begin
         base = i * COLS;
         if (cases[base] > 32'd5) begin
            $display("Case %0d has an unknown opcode %0h", i, cases[base]);
            abort_run();
         end
         if (cases[base+6] == GAP_RANDOM) begin
            gap = $unsigned($random(seed)) % 3;
         end else begin
            gap = cases[base+6];
         end
         op_valid = 1'b0;
         repeat (gap) @(negedge clk);
         op_valid  = 1'b1;
         op.opcode = alu_pipe_pkg::opcode_e'(cases[base][2:0]);
         op.rd     = cases[base+1][alu_pipe_pkg::RF_ADDR_W-1:0];
         op.ra     = cases[base+2][alu_pipe_pkg::RF_ADDR_W-1:0];
         op.rb     = cases[base+3][alu_pipe_pkg::RF_ADDR_W-1:0];
         op.imm    = cases[base+4][alu_pipe_pkg::IMM_W-1:0];
         exp_rec.valid = 1'b1;
         exp_rec.rd    = op.rd;
         exp_rec.value = cases[base+5];
         exp_q.push_back(exp_rec);
         @(negedge clk);
      end
      op_valid = 1'b0;
      op       = '0;

      // Last result is due four cycles after issue, the rest would expose an extra retire
      repeat (10) @(negedge clk);

      if (exp_q.size() != 0) begin
         $display("Only %0d of %0d operations retired", n_retired, n_cases);
         abort_run();
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

   // Three cycles per operation on average, plus reset and drain
   initial begin : watchdog
      #1;
      repeat (n_cases * 3 + 30) @(posedge clk);
      $display("Timeout after %0d cycles with %0d results outstanding",
               n_cases * 3 + 30, exp_q.size());
      abort_run();
   end

endmodule

//--- rtl/alu_exec.sv
/* Execute ALU with the control and writeback stage registers.
   Arithmetic wraps; wb_o is both the register file write and the retire record. */
`timescale 1ns/1ps

module alu_exec (
   input  logic                   clk,
   input  logic                   rst,
   input  alu_pipe_pkg::exec_op_t e_op_i,
   input  alu_pipe_pkg::word_t    ex_a_i,
   input  alu_pipe_pkg::word_t    ex_b_i,
   output alu_pipe_pkg::wr_t      ctrl_res_o,
   output alu_pipe_pkg::wr_t      wb_o
);

   localparam int PAD_W = alu_pipe_pkg::DATA_W - alu_pipe_pkg::IMM_W;

   alu_pipe_pkg::word_t alu_res;
   alu_pipe_pkg::wr_t   ctrl_q;
   alu_pipe_pkg::wr_t   wb_q;

   always_comb begin
      case (e_op_i.opcode)
         alu_pipe_pkg::OP_ADD: begin
            alu_res = ex_a_i + ex_b_i;
         end
         alu_pipe_pkg::OP_SUB: begin
            alu_res = ex_a_i - ex_b_i;
         end
         alu_pipe_pkg::OP_AND: begin
            alu_res = ex_a_i & ex_b_i;
         end
         alu_pipe_pkg::OP_OR: begin
            alu_res = ex_a_i | ex_b_i;
         end
         alu_pipe_pkg::OP_XOR: begin
            alu_res = ex_a_i ^ ex_b_i;
         end
         alu_pipe_pkg::OP_LDI: begin
            alu_res = {{PAD_W{1'b0}}, e_op_i.imm};
         end
         default: begin
            alu_res = '0;
         end
      endcase
   end

   // C stage, seen by the bypass logic
   always_ff @(posedge clk) begin
      ctrl_q.rd    <= e_op_i.rd;
      ctrl_q.value <= alu_res;
      if (rst) begin
         ctrl_q.valid <= 1'b0;
      end else begin
         ctrl_q.valid <= e_op_i.valid;
      end
   end

   // W stage
   always_ff @(posedge clk) begin
      wb_q.rd    <= ctrl_q.rd;
      wb_q.value <= ctrl_q.value;
      if (rst) begin
         wb_q.valid <= 1'b0;
      end else begin
         wb_q.valid <= ctrl_q.valid;
      end
   end

   assign ctrl_res_o = ctrl_q;
   assign wb_o       = wb_q;

endmodule

//--- rtl/alu_pipe_pkg.sv
/* Shared widths, opcodes and records of the five-stage datapath.
   All registers are DATA_W wide; register zero is an ordinary register. */

package alu_pipe_pkg;

   localparam int DATA_W    = 32;
   localparam int RF_ADDR_W = 4;
   localparam int IMM_W     = 16;

   typedef logic [DATA_W-1:0]    word_t;
   typedef logic [RF_ADDR_W-1:0] reg_adr_t;

   // OP_LDI zero-extends imm and ignores ra and rb
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_LDI = 3'd5
   } opcode_e;

   // Operation as presented at the issue port
   typedef struct packed {
      opcode_e            opcode;
      reg_adr_t           rd;
      reg_adr_t           ra;
      reg_adr_t           rb;
      logic [IMM_W-1:0]   imm;
   } op_t;

   // Operation in execute, read addresses already consumed
   typedef struct packed {
      logic               valid;
      opcode_e            opcode;
      reg_adr_t           rd;
      logic [IMM_W-1:0]   imm;
   } exec_op_t;

   // Register write, also used for the retire record and the C result
   typedef struct packed {
      logic               valid;
      reg_adr_t           rd;
      word_t              value;
   } wr_t;

endpackage

//--- rtl/alu_pipe_top.sv
/* Five-stage integer datapath, fixed four-cycle latency from op_valid_i to retire_o.
   No back-pressure; one operation may be strobed every cycle. */
`timescale 1ns/1ps

module alu_pipe_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              op_valid_i,
   input  alu_pipe_pkg::op_t op_i,
   output alu_pipe_pkg::wr_t retire_o
);

   logic                   fetch_rd_en;
   alu_pipe_pkg::reg_adr_t fetch_ra;
   alu_pipe_pkg::reg_adr_t fetch_rb;
   alu_pipe_pkg::reg_adr_t dec_ra;
   alu_pipe_pkg::reg_adr_t dec_rb;
   logic                   exec_wr;
   alu_pipe_pkg::reg_adr_t exec_rd;
   alu_pipe_pkg::exec_op_t e_op;
   alu_pipe_pkg::word_t    ex_a;
   alu_pipe_pkg::word_t    ex_b;
   alu_pipe_pkg::wr_t      ctrl_res;
   alu_pipe_pkg::wr_t      wb;

   pipe_ctrl u_pipe_ctrl (
      .clk           (clk),
      .rst           (rst),
      .op_valid_i    (op_valid_i),
      .op_i          (op_i),
      .fetch_rd_en_o (fetch_rd_en),
      .fetch_ra_o    (fetch_ra),
      .fetch_rb_o    (fetch_rb),
      .dec_ra_o      (dec_ra),
      .dec_rb_o      (dec_rb),
      .exec_wr_o     (exec_wr),
      .exec_rd_o     (exec_rd),
      .e_op_o        (e_op)
   );

   rf_bypass u_rf_bypass (
      .clk           (clk),
      .rst           (rst),
      .fetch_rd_en_i (fetch_rd_en),
      .fetch_ra_i    (fetch_ra),
      .fetch_rb_i    (fetch_rb),
      .dec_ra_i      (dec_ra),
      .dec_rb_i      (dec_rb),
      .exec_wr_i     (exec_wr),
      .exec_rd_i     (exec_rd),
      .ctrl_res_i    (ctrl_res),
      .wb_i          (wb),
      .ex_a_o        (ex_a),
      .ex_b_o        (ex_b)
   );

   alu_exec u_alu_exec (
      .clk        (clk),
      .rst        (rst),
      .e_op_i     (e_op),
      .ex_a_i     (ex_a),
      .ex_b_i     (ex_b),
      .ctrl_res_o (ctrl_res),
      .wb_o       (wb)
   );

   assign retire_o = wb;

endmodule

//--- rtl/pipe_ctrl.sv
/* Issue and decode stage registers; every strobed operation is accepted.
   Immediate loads write a register but issue no register file read. */
`timescale 1ns/1ps

module pipe_ctrl (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   op_valid_i,
   input  alu_pipe_pkg::op_t      op_i,
   output logic                   fetch_rd_en_o,
   output alu_pipe_pkg::reg_adr_t fetch_ra_o,
   output alu_pipe_pkg::reg_adr_t fetch_rb_o,
   output alu_pipe_pkg::reg_adr_t dec_ra_o,
   output alu_pipe_pkg::reg_adr_t dec_rb_o,
   output logic                   exec_wr_o,
   output alu_pipe_pkg::reg_adr_t exec_rd_o,
   output alu_pipe_pkg::exec_op_t e_op_o
);

   logic                   f_valid_q;
   alu_pipe_pkg::op_t      f_op_q;
   logic                   d_valid_q;
   alu_pipe_pkg::op_t      d_op_q;
   alu_pipe_pkg::exec_op_t e_op_q;

   always_ff @(posedge clk) begin
      f_op_q          <= op_i;
      d_op_q          <= f_op_q;
      e_op_q.opcode   <= d_op_q.opcode;
      e_op_q.rd       <= d_op_q.rd;
      e_op_q.imm      <= d_op_q.imm;
      if (rst) begin
         f_valid_q    <= 1'b0;
         d_valid_q    <= 1'b0;
         e_op_q.valid <= 1'b0;
      end else begin
         f_valid_q    <= op_valid_i;
         d_valid_q    <= f_valid_q;
         e_op_q.valid <= d_valid_q;
      end
   end

   // RAM read happens at the F-to-D edge
   assign fetch_rd_en_o = f_valid_q && (f_op_q.opcode != alu_pipe_pkg::OP_LDI);
   assign fetch_ra_o    = f_op_q.ra;
   assign fetch_rb_o    = f_op_q.rb;

   assign dec_ra_o      = d_op_q.ra;
   assign dec_rb_o      = d_op_q.rb;

   // Every valid operation in E writes its rd
   assign exec_wr_o     = e_op_q.valid;
   assign exec_rd_o     = e_op_q.rd;
   assign e_op_o        = e_op_q;

endmodule

//--- rtl/rf_bypass.sv
/* Register file reads with bypassing to decode and execute.
   Decode lasts exactly one cycle; there is no stall and no flush.
   An E-stage dependency is served from the C result one cycle later. */
`timescale 1ns/1ps

module rf_bypass (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   fetch_rd_en_i,
   input  alu_pipe_pkg::reg_adr_t fetch_ra_i,
   input  alu_pipe_pkg::reg_adr_t fetch_rb_i,
   input  alu_pipe_pkg::reg_adr_t dec_ra_i,
   input  alu_pipe_pkg::reg_adr_t dec_rb_i,
   input  logic                   exec_wr_i,
   input  alu_pipe_pkg::reg_adr_t exec_rd_i,
   input  alu_pipe_pkg::wr_t      ctrl_res_i,
   input  alu_pipe_pkg::wr_t      wb_i,
   output alu_pipe_pkg::word_t    ex_a_o,
   output alu_pipe_pkg::word_t    ex_b_o
);

   // Port 0 carries operand a, port 1 operand b
   alu_pipe_pkg::reg_adr_t fetch_adr [2];
   alu_pipe_pkg::reg_adr_t dec_adr   [2];
   alu_pipe_pkg::word_t    ex_dat    [2];

   assign fetch_adr[0] = fetch_ra_i;
   assign fetch_adr[1] = fetch_rb_i;
   assign dec_adr[0]   = dec_ra_i;
   assign dec_adr[1]   = dec_rb_i;

   for (genvar p = 0; p < 2; p++) begin : g_port
      alu_pipe_pkg::word_t ram_dat;
      alu_pipe_pkg::word_t fetch_wb_dat_q;
      logic                fetch_wb_hit_q;
      alu_pipe_pkg::word_t dec_dat;
      alu_pipe_pkg::word_t ex_dat_q;
      logic                ex_hazard_q;
      logic                ctrl_hit;
      logic                wb_hit;

      rf_ram u_ram (
         .clk      (clk),
         .rd_en_i  (fetch_rd_en_i),
         .rd_adr_i (fetch_adr[p]),
         .rd_dat_o (ram_dat),
         .wr_i     (wb_i)
      );

      // A write landing on the read edge is missed by the RAM,
      // so keep a copy of it for decode
      always_ff @(posedge clk) begin
         fetch_wb_dat_q <= wb_i.value;
         if (rst) begin
            fetch_wb_hit_q <= 1'b0;
         end else begin
            fetch_wb_hit_q <= fetch_rd_en_i & wb_i.valid & (wb_i.rd == fetch_adr[p]);
         end
      end

      assign ctrl_hit = ctrl_res_i.valid && (ctrl_res_i.rd == dec_adr[p]);
      assign wb_hit   = wb_i.valid && (wb_i.rd == dec_adr[p]);

      // Youngest producer wins
      always_comb begin
         if (ctrl_hit) begin
            dec_dat = ctrl_res_i.value;
         end else if (wb_hit) begin
            dec_dat = wb_i.value;
         end else if (fetch_wb_hit_q) begin
            dec_dat = fetch_wb_dat_q;
         end else begin
            dec_dat = ram_dat;
         end
      end

      // Producer in E has no result yet, flag it and pick it up from C
      always_ff @(posedge clk) begin
         ex_dat_q <= dec_dat;
         if (rst) begin
            ex_hazard_q <= 1'b0;
         end else begin
            ex_hazard_q <= exec_wr_i & (exec_rd_i == dec_adr[p]);
         end
      end

      assign ex_dat[p] = ex_hazard_q ? ctrl_res_i.value : ex_dat_q;
   end

   assign ex_a_o = ex_dat[0];
   assign ex_b_o = ex_dat[1];

endmodule

//--- rtl/rf_ram.sv
/* One-write one-read register file RAM, read data valid one cycle after rd_en_i.
   A read at the same edge as a write to that address returns the old word. */
`timescale 1ns/1ps

module rf_ram (
   input  logic                   clk,
   input  logic                   rd_en_i,
   input  alu_pipe_pkg::reg_adr_t rd_adr_i,
   output alu_pipe_pkg::word_t    rd_dat_o,
   input  alu_pipe_pkg::wr_t      wr_i
);

   alu_pipe_pkg::word_t mem [2**alu_pipe_pkg::RF_ADDR_W];
   alu_pipe_pkg::word_t rd_dat_q;

   always_ff @(posedge clk) begin
      if (wr_i.valid) begin
         mem[wr_i.rd] <= wr_i.value;
      end
      // Output holds while no read is issued
      if (rd_en_i) begin
         rd_dat_q <= mem[rd_adr_i];
      end
   end

   assign rd_dat_o = rd_dat_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
# The exit status of the simulation binary is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
   --top-module alu_pipe_tb \
   -f alu_pipe_top.f \
   --Mdir obj_dir -o alu_pipe_sim

./obj_dir/alu_pipe_sim
